//--- common/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// Architectural register count
`define LC3B_NUM_REGS 8

// Retire queue depth and its pointer width
`define LC3B_RETIRE_DEPTH 4
`define LC3B_RETIRE_PTR_W 2

`endif

//--- common/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;         // Data and instruction word
    typedef logic [2:0] lc3b_reg;           // Register index
    typedef logic signed [4:0] lc3b_imm5;   // ADD/AND immediate
    typedef logic [3:0] lc3b_imm4;          // SHF amount

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // Register writers of the supported subset
    function automatic logic op_writes_reg(input lc3b_opcode op);
        return (op == op_add) || (op == op_and) || (op == op_not) || (op == op_shf);
    endfunction

endpackage

//--- common/lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

    // Bypass select per EX source operand
    typedef enum logic [1:0] {
        fwd_none   = 2'b00,     // Register file value
        fwd_ex_mem = 2'b01,     // Younger result, one stage ahead
        fwd_mem_wb = 2'b10      // Older result, two stages ahead
    } fwd_sel_t;

    typedef enum logic [1:0] {
        intake_idle,
        intake_hold,            // Word captured, waiting to issue
        intake_ack,
        intake_wait_drop        // Ack high until the source drops req
    } intake_state_t;

    typedef enum logic {
        retire_idle,
        retire_req
    } retire_state_t;

    // One queued report, destination in the upper bits
    typedef logic [$bits(lc3b_isa_pkg::lc3b_reg) + $bits(lc3b_isa_pkg::lc3b_word) - 1:0]
        retire_rec_t;

endpackage

//--- common/retire_if.sv
interface retire_if;
    import lc3b_isa_pkg::*;

    logic     wb_valid;     // One record per register write
    lc3b_reg  wb_dr;
    lc3b_word wb_data;
    logic     freeze;       // Queue near full, stall everything

    modport pipe (
        output wb_valid,
        output wb_dr,
        output wb_data,
        input  freeze
    );

    modport port (
        input  wb_valid,
        input  wb_dr,
        input  wb_data,
        output freeze
    );

endinterface

//--- verilog/instr_intake.sv
module instr_intake (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_req,
    input  lc3b_isa_pkg::lc3b_word instr,
    output logic                   instr_ack,
    input  logic                   freeze,
    output logic                   issue_valid,
    output lc3b_isa_pkg::lc3b_word issue_ir
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    intake_state_t state;
    intake_state_t state_next;
    lc3b_word      ir_q;        // Captured instruction
    logic          accept;

    assign accept = (state == intake_idle) && instr_req && !freeze;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= intake_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ir_q <= instr;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            intake_idle: begin
                if (accept) begin
                    state_next = intake_hold;
                end
            end
            intake_hold: begin
                if (!freeze) begin
                    state_next = intake_ack;    // Issued this cycle
                end
            end
            intake_ack: begin
                state_next = instr_req ? intake_wait_drop : intake_idle;
            end
            intake_wait_drop: begin
                if (!instr_req) begin
                    state_next = intake_idle;
                end
            end
            default: state_next = intake_idle;
        endcase
    end

    // Single issue pulse on the first unfrozen cycle after capture
    assign issue_valid = (state == intake_hold) && !freeze;
    assign issue_ir    = ir_q;
    assign instr_ack   = (state == intake_ack) || (state == intake_wait_drop);

endmodule

//--- pipeline/forwarding_controller.sv
module forwarding_controller (
    input  lc3b_isa_pkg::lc3b_word  ir_ex,
    input  lc3b_isa_pkg::lc3b_word  ir_ex_mem,
    input  lc3b_isa_pkg::lc3b_word  ir_mem_wb,
    output lc3b_pipe_pkg::fwd_sel_t forward_a,
    output lc3b_pipe_pkg::fwd_sel_t forward_b
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_opcode op_ex;
    lc3b_opcode op_ex_mem;
    lc3b_opcode op_mem_wb;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    lc3b_reg    dr_ex_mem;
    lc3b_reg    dr_mem_wb;
    logic       ex_mem_has_dr;
    logic       mem_wb_has_dr;
    logic       uses_sr1;
    logic       uses_sr2;

    assign op_ex     = lc3b_opcode'(ir_ex[15:12]);
    assign op_ex_mem = lc3b_opcode'(ir_ex_mem[15:12]);
    assign op_mem_wb = lc3b_opcode'(ir_mem_wb[15:12]);
    assign sr1       = ir_ex[8:6];
    assign sr2       = ir_ex[2:0];
    assign dr_ex_mem = ir_ex_mem[11:9];
    assign dr_mem_wb = ir_mem_wb[11:9];

    // Bubbles decode as BR and never match
    assign ex_mem_has_dr = op_writes_reg(op_ex_mem);
    assign mem_wb_has_dr = op_writes_reg(op_mem_wb);

    always_comb begin
        uses_sr1 = 1'b0;
        uses_sr2 = 1'b0;
        case (op_ex)
            op_add, op_and: begin
                uses_sr1 = 1'b1;
                uses_sr2 = !ir_ex[5];   // Register form only
            end
            op_not, op_shf: begin
                uses_sr1 = 1'b1;
            end
            default: begin
                uses_sr1 = 1'b0;
                uses_sr2 = 1'b0;
            end
        endcase
    end

    // EX_MEM holds the younger result, so it is checked first
    always_comb begin
        forward_a = fwd_none;
        if (uses_sr1 && ex_mem_has_dr && (dr_ex_mem == sr1)) begin
            forward_a = fwd_ex_mem;
        end else if (uses_sr1 && mem_wb_has_dr && (dr_mem_wb == sr1)) begin
            forward_a = fwd_mem_wb;
        end
    end

    always_comb begin
        forward_b = fwd_none;
        if (uses_sr2 && ex_mem_has_dr && (dr_ex_mem == sr2)) begin
            forward_b = fwd_ex_mem;
        end else if (uses_sr2 && mem_wb_has_dr && (dr_mem_wb == sr2)) begin
            forward_b = fwd_mem_wb;
        end
    end

endmodule

//--- pipeline/lc3b_pipeline.sv
`include "lc3b_macros.svh"

module lc3b_pipeline (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  lc3b_isa_pkg::lc3b_word issue_ir,
    retire_if.pipe                 wb
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_word   regs [`LC3B_NUM_REGS];
    lc3b_word   id_ir;
    lc3b_word   idex_ir;
    lc3b_word   idex_a;
    lc3b_word   idex_b;
    lc3b_word   exmem_ir;
    lc3b_word   exmem_res;
    lc3b_word   memwb_ir;
    lc3b_word   memwb_res;
    lc3b_opcode issue_op;
    lc3b_opcode ex_op;
    lc3b_opcode wb_op;
    lc3b_reg    id_sr1;
    lc3b_reg    id_sr2;
    lc3b_reg    wb_dr_w;
    lc3b_word   rd_a;
    lc3b_word   rd_b;
    fwd_sel_t   forward_a;
    fwd_sel_t   forward_b;
    lc3b_word   alu_a;
    lc3b_word   alu_b;
    lc3b_word   alu_res;
    lc3b_word   imm_ext;
    lc3b_imm5   imm5;
    lc3b_imm4   shamt;
    logic       issue_ok;
    logic       advance;
    logic       rf_we;

    assign advance  = !wb.freeze;
    assign issue_op = lc3b_opcode'(issue_ir[15:12]);
    assign issue_ok = issue_valid && op_writes_reg(issue_op);  // Others become bubbles

    // ID stage with write-through from WB
    assign id_sr1 = id_ir[8:6];
    assign id_sr2 = id_ir[2:0];
    assign rd_a   = (rf_we && (wb_dr_w == id_sr1)) ? memwb_res : regs[id_sr1];
    assign rd_b   = (rf_we && (wb_dr_w == id_sr2)) ? memwb_res : regs[id_sr2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ir    <= '0;
            idex_ir  <= '0;
            exmem_ir <= '0;
            memwb_ir <= '0;
        end else if (advance) begin
            id_ir    <= issue_ok ? issue_ir : '0;
            idex_ir  <= id_ir;
            exmem_ir <= idex_ir;
            memwb_ir <= exmem_ir;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            idex_a    <= rd_a;
            idex_b    <= rd_b;
            exmem_res <= alu_res;
            memwb_res <= exmem_res;     // MEM stage passes data through
        end
    end

    forwarding_controller u_fwd (
        .ir_ex     (idex_ir),
        .ir_ex_mem (exmem_ir),
        .ir_mem_wb (memwb_ir),
        .forward_a (forward_a),
        .forward_b (forward_b)
    );

    always_comb begin
        case (forward_a)
            fwd_ex_mem: alu_a = exmem_res;
            fwd_mem_wb: alu_a = memwb_res;
            default:    alu_a = idex_a;
        endcase
        case (forward_b)
            fwd_ex_mem: alu_b = exmem_res;
            fwd_mem_wb: alu_b = memwb_res;
            default:    alu_b = idex_b;
        endcase
    end

    // EX stage ALU
    assign ex_op   = lc3b_opcode'(idex_ir[15:12]);
    assign imm5    = idex_ir[4:0];
    assign shamt   = idex_ir[3:0];
    assign imm_ext = {{11{imm5[4]}}, imm5};

    always_comb begin
        case (ex_op)
            op_add: alu_res = alu_a + (idex_ir[5] ? imm_ext : alu_b);
            op_and: alu_res = alu_a & (idex_ir[5] ? imm_ext : alu_b);
            op_not: alu_res = ~alu_a;
            op_shf: begin
                if (!idex_ir[4]) begin
                    alu_res = alu_a << shamt;       // LSHF
                end else if (!idex_ir[5]) begin
                    alu_res = alu_a >> shamt;       // RSHFL
                end else begin
                    alu_res = lc3b_word'($signed(alu_a) >>> shamt);
                end
            end
            default: alu_res = '0;
        endcase
    end

    // WB stage
    assign wb_op   = lc3b_opcode'(memwb_ir[15:12]);
    assign wb_dr_w = memwb_ir[11:9];
    assign rf_we   = op_writes_reg(wb_op) && advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[wb_dr_w] <= memwb_res;
        end
    end

    assign wb.wb_valid = rf_we;
    assign wb.wb_dr    = wb_dr_w;
    assign wb.wb_data  = memwb_res;

endmodule

//--- verilog/retire_port.sv
`include "lc3b_macros.svh"

module retire_port (
    input  logic                   clk,
    input  logic                   rst_n,
    retire_if.port                 wb,
    output logic                   ret_req,
    output lc3b_isa_pkg::lc3b_reg  ret_dr,
    output lc3b_isa_pkg::lc3b_word ret_data,
    input  logic                   ret_ack
);
    import lc3b_pipe_pkg::*;

    retire_rec_t                   queue [`LC3B_RETIRE_DEPTH];
    logic [`LC3B_RETIRE_PTR_W-1:0] wr_ptr;
    logic [`LC3B_RETIRE_PTR_W-1:0] rd_ptr;
    logic [`LC3B_RETIRE_PTR_W:0]   count;
    retire_state_t                 state;
    logic                          push;
    logic                          pop;

    assign push = wb.wb_valid;
    assign pop  = (state == retire_req) && ret_ack;

    // Leave room for a record already in flight
    assign wb.freeze = count >= (`LC3B_RETIRE_PTR_W + 1)'(`LC3B_RETIRE_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= {wb.wb_dr, wb.wb_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the queue depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Four-phase sender, next record only once ack is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= retire_idle;
        end else begin
            case (state)
                retire_idle: if ((count != '0) && !ret_ack) state <= retire_req;
                retire_req:  if (ret_ack) state <= retire_idle;
                default:     state <= retire_idle;
            endcase
        end
    end

    // Head record held steady while req is up
    always_ff @(posedge clk) begin
        if (state == retire_idle) begin
            {ret_dr, ret_data} <= queue[rd_ptr];
        end
    end

    assign ret_req = (state == retire_req);

endmodule

//--- verilog/lc3b_core_top.sv
module lc3b_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_req,
    input  lc3b_isa_pkg::lc3b_word instr,
    output logic                   instr_ack,
    output logic                   ret_req,
    output lc3b_isa_pkg::lc3b_reg  ret_dr,
    output lc3b_isa_pkg::lc3b_word ret_data,
    input  logic                   ret_ack
);
    import lc3b_isa_pkg::*;

    logic     issue_valid;
    lc3b_word issue_ir;

    retire_if wb_bus ();    // Writeback records and freeze

    instr_intake u_intake (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req   (instr_req),
        .instr       (instr),
        .instr_ack   (instr_ack),
        .freeze      (wb_bus.freeze),
        .issue_valid (issue_valid),
        .issue_ir    (issue_ir)
    );

    lc3b_pipeline u_pipeline (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_ir    (issue_ir),
        .wb          (wb_bus.pipe)
    );

    retire_port u_retire (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb_bus.port),
        .ret_req  (ret_req),
        .ret_dr   (ret_dr),
        .ret_data (ret_data),
        .ret_ack  (ret_ack)
    );

endmodule

//--- test/lc3b_core_sva.sv
module lc3b_core_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   instr_req,
    input logic                   instr_ack,
    input logic                   ret_req,
    input logic                   ret_ack,
    input lc3b_isa_pkg::lc3b_reg  ret_dr,
    input lc3b_isa_pkg::lc3b_word ret_data,
    input logic [1:0]             forward_a,
    input logic [1:0]             forward_b
);
    int fail_count = 0;

    ack_drop_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(instr_ack) |-> !$past(instr_req))
        else begin
            $error("instr_ack fell while instr_req was high");
            fail_count++;
        end

    // Record must not move until the sink answers
    ret_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ret_req && !ret_ack) |=> ($stable(ret_dr) && $stable(ret_data)))
        else begin
            $error("ret_dr or ret_data changed while waiting for ret_ack");
            fail_count++;
        end

    fwd_encoding: assert property (@(posedge clk) disable iff (!rst_n)
        (forward_a != 2'b11) && (forward_b != 2'b11))
        else begin
            $error("Forward select took the unused encoding");
            fail_count++;
        end

endmodule

bind lc3b_core_top lc3b_core_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr_ack (instr_ack),
    .ret_req   (ret_req),
    .ret_ack   (ret_ack),
    .ret_dr    (ret_dr),
    .ret_data  (ret_data),
    .forward_a (u_pipeline.forward_a),
    .forward_b (u_pipeline.forward_b)
);

//--- test/lc3b_core_tb.sv
module lc3b_core_tb;
    import lc3b_isa_pkg::*;

    localparam int       WAIT_LIMIT = 400;          // Cycles allowed per wait loop
    localparam lc3b_word LFSR_SEED  = 16'd25612;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     instr_req;
    lc3b_word instr;
    logic     instr_ack;
    logic     ret_req;
    lc3b_reg  ret_dr;
    lc3b_word ret_data;
    logic     ret_ack;

    lc3b_word model_regs [8];
    lc3b_reg  exp_dr [$];
    lc3b_word exp_data [$];
    lc3b_reg  got_dr [$];
    lc3b_word got_data [$];
    lc3b_word lfsr;
    int       ack_delay;
    int       report_count;
    int       error_count;
    int       check_count;
    int       max_ack_wait;
    logic     timed_out;

    lc3b_core_top DUT (.*);

    always #2 clk = ~clk;

    // Sink side of the retire handshake
    initial begin
        int waited;
        ret_ack = 1'b0;
        waited = 0;
        forever begin
            @(negedge clk);
            if (ret_req && !ret_ack) begin
                if (waited >= ack_delay) begin
                    got_dr.push_back(ret_dr);
                    got_data.push_back(ret_data);
                    report_count++;
                    ret_ack = 1'b1;
                    waited = 0;
                end else begin
                    waited++;
                end
            end else if (ret_ack && !ret_req) begin
                ret_ack = 1'b0;
            end
        end
    end

    function automatic lc3b_word lfsr_next(input lc3b_word s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output lc3b_word v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic lc3b_word encode(input lc3b_opcode op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input logic [5:0] low6);
        return {op, dr, sr1, low6};
    endfunction

    // Architectural model, one instruction in program order
    task automatic model_exec(input lc3b_word ir);
        lc3b_word a;
        lc3b_word b;
        lc3b_word res;
        a = model_regs[ir[8:6]];
        b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
        case (lc3b_opcode'(ir[15:12]))
            op_add: res = a + b;
            op_and: res = a & b;
            op_not: res = ~a;
            op_shf: begin
                if (!ir[4]) begin
                    res = a << ir[3:0];
                end else if (!ir[5]) begin
                    res = a >> ir[3:0];
                end else begin
                    res = $signed(a) >>> ir[3:0];
                end
            end
            default: return;                    // No register write, no report
        endcase
        model_regs[ir[11:9]] = res;
        exp_dr.push_back(ir[11:9]);
        exp_data.push_back(res);
    endtask

    task automatic note_timeout(input string what);
        if (!timed_out) begin
            $display("Timeout at %0t: %s", $time, what);
            error_count++;
        end
        timed_out = 1'b1;
    endtask

    // Four-phase send, called and left on a falling edge
    task automatic send_instr(input lc3b_word ir);
        int t;
        if (timed_out) return;
        instr     = ir;
        instr_req = 1'b1;
        t = 0;
        while (!instr_ack && !timed_out) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) note_timeout("instr_ack never rose");
        end
        max_ack_wait = (t > max_ack_wait) ? t : max_ack_wait;
        instr_req = 1'b0;
        t = 0;
        while (instr_ack && !timed_out) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) note_timeout("instr_ack never fell");
        end
        model_exec(ir);
    endtask

    task automatic send_random_alu();
        lc3b_word v;
        take_bits(13, v);
        send_instr(encode(v[0] ? op_and : op_add, v[3:1], v[6:4],
                          v[7] ? {1'b1, v[12:8]} : {3'b000, v[10:8]}));
    endtask

    task automatic check_results(input string name);
        int t;
        t = 0;
        while ((got_dr.size() < exp_dr.size()) && !timed_out) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) note_timeout({name, ": reports missing"});
        end
        repeat (16) @(negedge clk);             // Window for stray reports
        if (!timed_out) begin
            check_count++;
            if (got_dr.size() != exp_dr.size()) begin
                $display("%s: expected %0d reports but received %0d", name,
                         exp_dr.size(), got_dr.size());
                error_count++;
            end
            for (int i = 0; (i < exp_dr.size()) && (i < got_dr.size()); i++) begin
                check_count++;
                if ((got_dr[i] != exp_dr[i]) || (got_data[i] != exp_data[i])) begin
                    $display("FAILED at %0t: %s report %0d is R%0d=%h, expected R%0d=%h",
                             $time, name, i, got_dr[i], got_data[i], exp_dr[i], exp_data[i]);
                    error_count++;
                end
            end
        end
        exp_dr.delete();
        exp_data.delete();
        got_dr.delete();
        got_data.delete();
    endtask

    task automatic run_imm_ops();
        lc3b_word v;
        ack_delay = 0;
        for (int r = 1; r < 8; r++) begin
            take_bits(5, v);
            send_instr(encode(op_add, lc3b_reg'(r), 3'd0, {1'b1, v[4:0]}));
        end
        for (int r = 1; r < 4; r++) begin
            take_bits(5, v);
            send_instr(encode(op_and, lc3b_reg'(r), lc3b_reg'(r + 4), {1'b1, v[4:0]}));
        end
        check_results("imm ops");
    endtask

    // Each instruction reads the previous destination
    task automatic chain_dependent_ops();
        lc3b_word v;
        lc3b_reg  prev;
        ack_delay = 0;
        prev = 3'd1;
        for (int i = 0; i < 10; i++) begin
            take_bits(6, v);
            send_instr(encode(v[0] ? op_and : op_add, v[3:1], i[0] ? v[5:3] : prev,
                              {3'b000, i[0] ? prev : v[5:3]}));
            prev = v[3:1];
        end
        send_instr(encode(op_add, 3'd7, prev, {3'b000, prev}));
        check_results("dependent chain");
    endtask

    task automatic forward_two_apart();
        lc3b_word v;
        lc3b_word w;
        ack_delay = 5;                          // Queue pressure closes the gaps
        for (int i = 0; i < 3; i++) begin
            take_bits(5, v);
            take_bits(5, w);
            send_instr(encode(op_add, 3'd5, lc3b_reg'(i + 1), {1'b1, v[4:0]}));
            send_instr(encode(op_and, 3'd4, lc3b_reg'(i + 2), {1'b1, w[4:0]}));
            send_instr(encode(op_add, 3'd3, 3'd5, {3'b000, 3'd4}));
            send_instr(encode(op_add, 3'd6, 3'd5, {1'b1, v[4:0]}));
            send_instr(encode(op_add, 3'd6, 3'd3, {1'b1, w[4:0]}));
            send_instr(encode(op_and, 3'd2, 3'd6, {3'b000, 3'd6}));    // Younger R6 wins
        end
        check_results("two apart");
    endtask

    task automatic shift_not_chains();
        lc3b_word k;
        lc3b_word d;
        lc3b_reg  prev;
        ack_delay = 3;
        prev = 3'd6;
        for (int i = 0; i < 12; i++) begin
            take_bits(6, k);
            take_bits(3, d);
            case (k[5:4])
                2'd0:    send_instr(encode(op_shf, d[2:0], prev, {2'b00, k[3:0]}));
                2'd1:    send_instr(encode(op_shf, d[2:0], prev, {2'b01, k[3:0]}));
                2'd2:    send_instr(encode(op_shf, d[2:0], prev, {2'b11, k[3:0]}));
                default: send_instr(encode(op_not, d[2:0], prev, 6'h3F));
            endcase
            prev = d[2:0];
        end
        check_results("not and shift");
    endtask

    task automatic stall_under_backpressure();
        ack_delay = 12;
        max_ack_wait = 0;
        for (int i = 0; i < 16; i++) begin
            send_random_alu();
        end
        check_results("back-pressure");
        check_count++;
        if (!timed_out && (max_ack_wait <= 2)) begin
            $display("Back-pressure never held off instr_ack");
            error_count++;
        end
    endtask

    task automatic skip_unsupported();
        lc3b_word v;
        int       start;
        int       n_ok;
        ack_delay = 2;
        start = report_count;
        n_ok = 0;
        for (int i = 0; i < 10; i++) begin
            send_random_alu();
            n_ok++;
            take_bits(16, v);
            if (v[13:12] == 2'b01) v[13] = 1'b1;   // Steer off the four writers
            send_instr(v);
        end
        check_results("unsupported");
        check_count++;
        if (!timed_out && (report_count - start != n_ok)) begin
            $display("Unsupported mix gave %0d reports for %0d supported instructions",
                     report_count - start, n_ok);
            error_count++;
        end
    endtask

    initial begin
        int sva_errors;
        rst_n        = 1'b0;
        instr_req    = 1'b0;
        instr        = '0;
        lfsr         = LFSR_SEED;
        ack_delay    = 0;
        report_count = 0;
        error_count  = 0;
        check_count  = 0;
        max_ack_wait = 0;
        timed_out    = 1'b0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        run_imm_ops();
        chain_dependent_ops();
        forward_two_apart();
        shift_not_chains();
        stall_under_backpressure();
        skip_unsupported();
        sva_errors = DUT.u_sva.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, sva_errors);
        if ((error_count == 0) && (sva_errors == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/lc3b_isa_pkg.sv
common/lc3b_pipe_pkg.sv
common/retire_if.sv
verilog/instr_intake.sv
pipeline/forwarding_controller.sv
pipeline/lc3b_pipeline.sv
verilog/retire_port.sv
verilog/lc3b_core_top.sv
test/lc3b_core_sva.sv
test/lc3b_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lc3b_core_tb -f build.f -o lc3b_core_sim

./obj_dir/lc3b_core_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
